// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // data and address word
    typedef logic [31:0] xlen_t;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // control transfer class resolved in execute
    typedef enum logic [1:0] {
        br_none,
        br_jal,
        br_jalr,
        br_branch
    } br_kind_e;

    // decode to execute record
    typedef struct packed {
        xlen_t      pc;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       reg_write;
        alu_op_e    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        logic       a_is_zero;
        br_kind_e   br_kind;
        logic [2:0] func3;
        xlen_t      imm;
    } dec_op_t;

    // execute to writeback record
    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        logic     reg_write;
        xlen_t    result;
    } ex_res_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
    parameter int num_regs = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1_addr,
    input  rv_pkg::reg_idx_t rs2_addr,
    output rv_pkg::xlen_t    rs1_data,
    output rv_pkg::xlen_t    rs2_data,
    input  logic             wen,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::xlen_t    wdata
);

    rv_pkg::xlen_t regs [num_regs];

    // x0 and indices past num_regs read as zero
    assign rs1_data = (rs1_addr == '0 || rs1_addr >= num_regs) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0 || rs2_addr >= num_regs) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0 && waddr < num_regs) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetch_valid,
    output logic            fetch_ready,
    input  rv_pkg::xlen_t   fetch_inst,
    input  rv_pkg::xlen_t   fetch_pc,
    input  logic            redirect,
    output logic            id_valid,
    input  logic            id_ready,
    output rv_pkg::dec_op_t id_op
);

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    logic [6:0]      opcode;
    logic [2:0]      func3;
    logic [6:0]      func7;
    logic            func7_ok;
    rv_pkg::xlen_t   imm_i;
    rv_pkg::xlen_t   imm_u;
    rv_pkg::xlen_t   imm_j;
    rv_pkg::xlen_t   imm_b;
    rv_pkg::xlen_t   shamt;
    rv_pkg::dec_op_t dec;

    function automatic rv_pkg::alu_op_e f3_alu(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  op = rv_pkg::alu_sll;
            3'b010:  op = rv_pkg::alu_slt;
            3'b011:  op = rv_pkg::alu_sltu;
            3'b100:  op = rv_pkg::alu_xor;
            3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  op = rv_pkg::alu_or;
            default: op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = fetch_inst[6:0];
    assign func3  = fetch_inst[14:12];
    assign func7  = fetch_inst[31:25];

    assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
    assign imm_u = {fetch_inst[31:12], 12'b0};
    assign imm_j = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
                    fetch_inst[30:21], 1'b0};
    assign imm_b = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
                    fetch_inst[11:8], 1'b0};
    assign shamt = {27'b0, fetch_inst[24:20]};

    // only sub and sra carry the alternate func7
    assign func7_ok = (func7 == 7'b0000000) ||
                      (func7 == 7'b0100000 && (func3 == 3'b000 || func3 == 3'b101));

    always_comb begin
        dec         = '0;
        dec.pc      = fetch_pc;
        dec.rs1     = fetch_inst[19:15];
        dec.rs2     = fetch_inst[24:20];
        dec.rd      = fetch_inst[11:7];
        dec.func3   = func3;
        dec.alu_op  = rv_pkg::alu_add;
        dec.br_kind = rv_pkg::br_none;
        case (opcode)
            op_lui: begin
                dec.reg_write = 1'b1;
                dec.a_is_zero = 1'b1;
                dec.b_is_imm  = 1'b1;
                dec.imm       = imm_u;
            end
            op_auipc: begin
                dec.reg_write = 1'b1;
                dec.a_is_pc   = 1'b1;
                dec.b_is_imm  = 1'b1;
                dec.imm       = imm_u;
            end
            op_jal: begin
                dec.reg_write = 1'b1;
                dec.a_is_pc   = 1'b1;
                dec.br_kind   = rv_pkg::br_jal;
                dec.imm       = imm_j;
            end
            op_jalr: begin
                dec.reg_write = (func3 == 3'b000);
                dec.a_is_pc   = 1'b1;
                dec.br_kind   = (func3 == 3'b000) ? rv_pkg::br_jalr : rv_pkg::br_none;
                dec.imm       = imm_i;
            end
            op_branch: begin
                dec.imm = imm_b;
                if (func3[2:1] != 2'b01) begin
                    dec.br_kind = rv_pkg::br_branch;
                end
                // beq and bne compare by subtract and the rest by set-less-than
                case (func3[2:1])
                    2'b10:   dec.alu_op = rv_pkg::alu_slt;
                    2'b11:   dec.alu_op = rv_pkg::alu_sltu;
                    default: dec.alu_op = rv_pkg::alu_sub;
                endcase
            end
            op_imm: begin
                dec.b_is_imm  = 1'b1;
                dec.alu_op    = f3_alu(func3, func7[5] && func3 == 3'b101);
                dec.imm       = (func3[1:0] == 2'b01) ? shamt : imm_i;
                dec.reg_write = (func3[1:0] != 2'b01) || func7_ok;
            end
            op_reg: begin
                dec.alu_op    = f3_alu(func3, func7[5]);
                dec.reg_write = func7_ok;
            end
            default: begin
                dec.reg_write = 1'b0;
            end
        endcase
    end

    assign fetch_ready = (id_ready || !id_valid) && !redirect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (redirect) begin
            id_valid <= 1'b0;
        end else if (fetch_valid && fetch_ready) begin
            id_valid <= 1'b1;
        end else if (id_ready) begin
            id_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            id_op <= dec;
        end
    end

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            id_valid,
    output logic            ex_ready,
    input  rv_pkg::dec_op_t id_op,
    input  rv_pkg::xlen_t   rs1_data,
    input  rv_pkg::xlen_t   rs2_data,
    input  logic            wb_fwd_valid,
    input  rv_pkg::ex_res_t wb_fwd,
    output logic            ex_valid,
    input  logic            wb_ready,
    output rv_pkg::ex_res_t ex_res,
    output logic            redirect,
    output rv_pkg::xlen_t   redirect_pc
);

    logic          fwd1_ex;
    logic          fwd1_wb;
    logic          fwd2_ex;
    logic          fwd2_wb;
    rv_pkg::xlen_t src1;
    rv_pkg::xlen_t src2;
    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t alu_res;
    logic          alu_zero;
    logic          alu_less;
    logic          is_jump;
    logic          take_branch;
    logic          fire;

    // execute register has priority over the retire register
    assign fwd1_ex = ex_valid && ex_res.reg_write && ex_res.rd != '0 && ex_res.rd == id_op.rs1;
    assign fwd2_ex = ex_valid && ex_res.reg_write && ex_res.rd != '0 && ex_res.rd == id_op.rs2;
    assign fwd1_wb = wb_fwd_valid && wb_fwd.reg_write && wb_fwd.rd != '0 &&
                     wb_fwd.rd == id_op.rs1;
    assign fwd2_wb = wb_fwd_valid && wb_fwd.reg_write && wb_fwd.rd != '0 &&
                     wb_fwd.rd == id_op.rs2;

    assign src1 = fwd1_ex ? ex_res.result : (fwd1_wb ? wb_fwd.result : rs1_data);
    assign src2 = fwd2_ex ? ex_res.result : (fwd2_wb ? wb_fwd.result : rs2_data);

    assign is_jump = (id_op.br_kind == rv_pkg::br_jal) || (id_op.br_kind == rv_pkg::br_jalr);

    always_comb begin
        if (id_op.a_is_zero) begin
            op_a = '0;
        end else if (id_op.a_is_pc) begin
            op_a = id_op.pc;
        end else begin
            op_a = src1;
        end
        // jumps write the link address pc + 4
        if (is_jump) begin
            op_b = 32'd4;
        end else if (id_op.b_is_imm) begin
            op_b = id_op.imm;
        end else begin
            op_b = src2;
        end
    end

    always_comb begin
        case (id_op.alu_op)
            rv_pkg::alu_add:  alu_res = op_a + op_b;
            rv_pkg::alu_sub:  alu_res = op_a - op_b;
            rv_pkg::alu_and:  alu_res = op_a & op_b;
            rv_pkg::alu_or:   alu_res = op_a | op_b;
            rv_pkg::alu_xor:  alu_res = op_a ^ op_b;
            rv_pkg::alu_slt:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu: alu_res = {31'b0, op_a < op_b};
            rv_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
            rv_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
            rv_pkg::alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            default:          alu_res = '0;
        endcase
        alu_zero = (alu_res == '0);
        alu_less = alu_res[0] && (id_op.alu_op == rv_pkg::alu_slt ||
                                  id_op.alu_op == rv_pkg::alu_sltu);
    end

    always_comb begin
        take_branch = 1'b0;
        if (id_op.br_kind == rv_pkg::br_branch) begin
            case (id_op.func3)
                3'b000:  take_branch = alu_zero;
                3'b001:  take_branch = !alu_zero;
                3'b100:  take_branch = alu_less;
                3'b101:  take_branch = !alu_less;
                3'b110:  take_branch = alu_less;
                3'b111:  take_branch = !alu_less;
                default: take_branch = 1'b0;
            endcase
        end
    end

    assign fire     = id_valid && ex_ready;
    assign redirect = fire && (is_jump || take_branch);

    // jalr target from forwarded rs1 with bit 0 cleared
    assign redirect_pc = (id_op.br_kind == rv_pkg::br_jalr) ?
                         ((src1 + id_op.imm) & ~32'h1) : (id_op.pc + id_op.imm);

    assign ex_ready = wb_ready || !ex_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (fire) begin
            ex_valid <= 1'b1;
        end else if (wb_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            ex_res.pc        <= id_op.pc;
            ex_res.rd        <= id_op.rd;
            ex_res.reg_write <= id_op.reg_write;
            ex_res.result    <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module wb_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             ex_valid,
    output logic             wb_ready,
    input  rv_pkg::ex_res_t  ex_res,
    output logic             retire_valid,
    input  logic             retire_ready,
    output rv_pkg::xlen_t    retire_pc,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::xlen_t    retire_data,
    output logic             rf_wen,
    output rv_pkg::reg_idx_t rf_waddr,
    output rv_pkg::xlen_t    rf_wdata
);

    rv_pkg::ex_res_t ret_q;

    assign wb_ready = retire_ready || !retire_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else if (ex_valid && wb_ready) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && wb_ready) begin
            ret_q <= ex_res;
        end
    end

    // non-writing instructions retire with rd and data zero
    assign retire_pc   = ret_q.pc;
    assign retire_rd   = ret_q.reg_write ? ret_q.rd : '0;
    assign retire_data = ret_q.reg_write ? ret_q.result : '0;

    // register write lands on the retire handshake
    assign rf_wen   = retire_valid && retire_ready && ret_q.reg_write && ret_q.rd != '0;
    assign rf_waddr = ret_q.rd;
    assign rf_wdata = ret_q.result;

endmodule

`default_nettype wire

// File: ex_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

module ex_pipe_top #(
    parameter int num_regs = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             fetch_valid,
    output logic             fetch_ready,
    input  rv_pkg::xlen_t    fetch_inst,
    input  rv_pkg::xlen_t    fetch_pc,
    output logic             retire_valid,
    input  logic             retire_ready,
    output rv_pkg::xlen_t    retire_pc,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::xlen_t    retire_data,
    output logic             redirect,
    output rv_pkg::xlen_t    redirect_pc
);

    logic             id_valid;
    logic             ex_ready;
    rv_pkg::dec_op_t  id_op;
    logic             ex_valid;
    logic             wb_ready;
    rv_pkg::ex_res_t  ex_res;
    rv_pkg::ex_res_t  wb_fwd;
    rv_pkg::xlen_t    rs1_data;
    rv_pkg::xlen_t    rs2_data;
    logic             rf_wen;
    rv_pkg::reg_idx_t rf_waddr;
    rv_pkg::xlen_t    rf_wdata;

    // retire entry fed back as the older forwarding source
    assign wb_fwd.pc        = retire_pc;
    assign wb_fwd.rd        = retire_rd;
    assign wb_fwd.reg_write = (retire_rd != '0);
    assign wb_fwd.result    = retire_data;

    id_stage u_id (
        .clk, .reset, .fetch_valid, .fetch_ready, .fetch_inst, .fetch_pc,
        .redirect, .id_valid, .id_ready(ex_ready), .id_op
    );

    ex_stage u_ex (
        .clk, .reset, .id_valid, .ex_ready, .id_op, .rs1_data, .rs2_data,
        .wb_fwd_valid(retire_valid), .wb_fwd, .ex_valid, .wb_ready, .ex_res,
        .redirect, .redirect_pc
    );

    wb_stage u_wb (
        .clk, .reset, .ex_valid, .wb_ready, .ex_res, .retire_valid, .retire_ready,
        .retire_pc, .retire_rd, .retire_data, .rf_wen, .rf_waddr, .rf_wdata
    );

    reg_file #(.num_regs(num_regs)) u_rf (
        .clk, .reset, .rs1_addr(id_op.rs1), .rs2_addr(id_op.rs2), .rs1_data, .rs2_data,
        .wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
    );

endmodule

`default_nettype wire

// File: ex_pipe_assert.sv
`timescale 1ns/1ns
`default_nettype none

module ex_pipe_assert #(
    parameter int width = 32
) (
    input logic             clk,
    input logic             reset,
    input logic             valid,
    input logic             ready,
    input logic             flush,
    input logic [width-1:0] payload
);

    // an offer holds with a stable payload until taken or flushed
    a_hold: assert property (@(posedge clk) disable iff (reset)
        valid && !ready && !flush |=> valid && $stable(payload))
        else $error("valid dropped or payload changed before the transfer");

    a_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({valid, ready}))
        else $error("handshake signal unknown");

endmodule

bind wb_stage ex_pipe_assert #(.width(69)) u_retire_chk (
    .clk(clk), .reset(reset), .valid(retire_valid), .ready(retire_ready),
    .flush(1'b0), .payload({retire_pc, retire_rd, retire_data})
);

bind id_stage ex_pipe_assert #(.width(64)) u_fetch_chk (
    .clk(clk), .reset(reset), .valid(fetch_valid), .ready(fetch_ready),
    .flush(redirect), .payload({fetch_pc, fetch_inst})
);

bind id_stage ex_pipe_assert #(.width($bits(rv_pkg::dec_op_t))) u_decode_chk (
    .clk(clk), .reset(reset), .valid(id_valid), .ready(id_ready),
    .flush(redirect), .payload(id_op)
);

`default_nettype wire

// File: tb_ex_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ex_pipe;

    localparam int clk_half = 2;
    localparam int cycles_per_check = 40;

    logic             clk;
    logic             reset;
    logic             fetch_valid;
    logic             fetch_ready;
    rv_pkg::xlen_t    fetch_inst;
    rv_pkg::xlen_t    fetch_pc;
    logic             retire_valid;
    logic             retire_ready;
    rv_pkg::xlen_t    retire_pc;
    rv_pkg::reg_idx_t retire_rd;
    rv_pkg::xlen_t    retire_data;
    logic             redirect;
    rv_pkg::xlen_t    redirect_pc;

    rv_pkg::xlen_t    imem [rv_pkg::xlen_t];
    rv_pkg::xlen_t    exp_pc [$];
    rv_pkg::reg_idx_t exp_rd [$];
    rv_pkg::xlen_t    exp_data [$];
    int               exp_group [$];
    rv_pkg::xlen_t    pc;
    integer           seed;
    bit               loaded;
    int               idx;
    int               errors;
    int               checks;
    int               group_checks;
    int               group_errors;

    ex_pipe_top #(.num_regs(32)) dut (
        .clk(clk), .reset(reset), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .fetch_inst(fetch_inst), .fetch_pc(fetch_pc), .retire_valid(retire_valid),
        .retire_ready(retire_ready), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .redirect(redirect), .redirect_pc(redirect_pc)
    );

    // unloaded words decode as addi x0 with an address-derived immediate
    function automatic rv_pkg::xlen_t fill_word(input rv_pkg::xlen_t addr);
        logic [11:0] imm;
        imm = addr[31:20] ^ addr[19:8] ^ {4'b0, addr[7:0]};
        return {imm, 20'h00013};
    endfunction

    function automatic rv_pkg::xlen_t fetch_word(input rv_pkg::xlen_t addr);
        if (imem.exists(addr)) begin
            return imem[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic string group_name(input int g);
        case (g)
            1:       return "alu operations";
            2:       return "forwarding chain";
            3:       return "x0 writes";
            4:       return "conditional branches";
            default: return "jumps, loop and unknown word";
        endcase
    endfunction

    task automatic load_testdata();
        int            fd;
        int            n;
        int            grp;
        logic [7:0]    tag;
        rv_pkg::xlen_t f0;
        rv_pkg::xlen_t f1;
        rv_pkg::xlen_t f2;
        string         line;
        fd = $fopen("ex_pipe_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open ex_pipe_testdata.txt");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "#") begin
                    n = $fgets(line, fd);
                end else if (tag == "I") begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    if (n != 2) begin
                        errors++;
                        $display("incomplete instruction record in test data");
                    end
                    imem[f0] = f1;
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%h %h %h %d", f0, f1, f2, grp);
                    if (n != 4) begin
                        errors++;
                        $display("incomplete expected record in test data");
                    end
                    exp_pc.push_back(f0);
                    exp_rd.push_back(f1[4:0]);
                    exp_data.push_back(f2);
                    exp_group.push_back(grp);
                end else begin
                    errors++;
                    $display("unknown record tag in test data");
                end
            end
            $fclose(fd);
        end
        if (exp_pc.size() == 0) begin
            errors++;
            $display("test data holds no expected retirements");
        end
    endtask

    // offers the word at pc and holds a pending offer
    task automatic drive_inputs(input bit hold);
        if (!hold) begin
            fetch_valid = ($random(seed) & 3) != 0;
        end
        fetch_pc = pc;
        fetch_inst = fetch_word(pc);
        retire_ready = ($random(seed) & 3) != 0;
    endtask

    task automatic check_retire(input rv_pkg::xlen_t pc_got, input rv_pkg::reg_idx_t rd_got,
                                input rv_pkg::xlen_t data_got);
        int bad;
        bad = 0;
        if (pc_got !== exp_pc[idx]) begin
            $display("FAIL t=%0t retire_pc expected %h actual %h", $time, exp_pc[idx], pc_got);
            bad++;
        end
        if (rd_got !== exp_rd[idx]) begin
            $display("FAIL t=%0t retire_rd expected %0d actual %0d", $time, exp_rd[idx], rd_got);
            bad++;
        end
        if (data_got !== exp_data[idx]) begin
            $display("FAIL t=%0t retire_data expected %h actual %h", $time, exp_data[idx],
                     data_got);
            bad++;
        end
        checks++;
        group_checks++;
        errors += bad;
        group_errors += bad;
        // group closes when the next entry starts another one
        if (idx + 1 == exp_pc.size() || exp_group[idx + 1] != exp_group[idx]) begin
            $display("group %0d (%s): %0d retirements, %0d errors", exp_group[idx],
                     group_name(exp_group[idx]), group_checks, group_errors);
            group_checks = 0;
            group_errors = 0;
        end
        idx++;
    endtask

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    initial begin
        wait (loaded);
        repeat (exp_pc.size() * cycles_per_check + 10) @(posedge clk);
        $display("timeout after %0d of %0d retirements", idx, exp_pc.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        bit            f_fire;
        bit            r_fire;
        bit            redir;
        rv_pkg::xlen_t target;
        rv_pkg::xlen_t got_pc;
        rv_pkg::xlen_t got_data;
        rv_pkg::reg_idx_t got_rd;
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_inst = '0;
        fetch_pc = '0;
        retire_ready = 1'b0;
        seed = 81879;
        pc = '0;
        load_testdata();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        if (retire_valid !== 1'b0 || redirect !== 1'b0 || fetch_ready !== 1'b1) begin
            errors++;
            $display("retire_valid, redirect or fetch_ready not at reset value after reset");
        end
        drive_inputs(1'b0);
        while (idx < exp_pc.size()) begin
            // sample mid-cycle and act just after the edge
            @(negedge clk);
            f_fire = fetch_valid && fetch_ready;
            r_fire = retire_valid && retire_ready;
            redir = redirect;
            target = redirect_pc;
            got_pc = retire_pc;
            got_rd = retire_rd;
            got_data = retire_data;
            @(posedge clk);
            #1;
            if (redir) begin
                pc = target;
            end else if (f_fire) begin
                pc = pc + 32'd4;
            end
            if (r_fire) begin
                check_retire(got_pc, got_rd, got_data);
            end
            drive_inputs(fetch_valid && !f_fire && !redir);
        end
        $display("retirements checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ex_pipe_testdata.txt
# I <addr> <word> : instruction memory word, hex
# E <pc> <rd> <data> <group> : expected retirement in program order, hex except group
I 00 800000B7 I 04 FFB00113 I 08 00700193 I 0C 00310233
I 10 402182B3 I 14 00312333 I 18 003133B3 I 1C 4030D433
I 20 0030D4B3 I 24 00319533 I 28 003145B3 I 2C 00316633
I 30 003176B3 I 34 FFC12713 I 38 FFF1B793 I 3C 0F01C813
I 40 1001E893 I 44 0FF17913 I 48 00419993 I 4C 01C15A13
I 50 40115A93 I 54 12345B17 I 58 00100B93 I 5C 017B8BB3
I 60 017B8BB3 I 64 004B8C33 I 68 417C0CB3 I 6C 03700013
I 70 00000D33 I 74 00D18463 I 78 00D19663 I 7C 00100D93
I 80 00200D93 I 84 00314463 I 88 00300D93 I 8C 00316463
I 90 00315463 I 94 00317463 I 98 00400D93 I 9C 01A00463
I A0 00500D93 I A4 00C00E6F I A8 00600D93 I AC 00700D93
I B0 010E0EE7 I B4 00800D93 I B8 01CE8F33 I BC 0C500FE7
I C0 00900D93 I C4 00200293 I C8 FFF28293 I CC FE029EE3
I D0 01F28333 I D4 FFFFFFFF I D8 ABCDE3B7
E 00 01 80000000 1  E 04 02 FFFFFFFB 1  E 08 03 00000007 1  E 0C 04 00000002 1
E 10 05 0000000C 1  E 14 06 00000001 1  E 18 07 00000000 1  E 1C 08 FF000000 1
E 20 09 01000000 1  E 24 0A 00000380 1  E 28 0B FFFFFFFC 1  E 2C 0C FFFFFFFF 1
E 30 0D 00000003 1  E 34 0E 00000001 1  E 38 0F 00000001 1  E 3C 10 000000F7 1
E 40 11 00000107 1  E 44 12 000000FB 1  E 48 13 00000070 1  E 4C 14 0000000F 1
E 50 15 FFFFFFFD 1  E 54 16 12345054 1  E 58 17 00000001 2  E 5C 17 00000002 2
E 60 17 00000004 2  E 64 18 00000006 2  E 68 19 00000002 2  E 6C 00 00000037 3
E 70 1A 00000000 3  E 74 00 00000000 4  E 78 00 00000000 4  E 84 00 00000000 4
E 8C 00 00000000 4  E 90 00 00000000 4  E 94 00 00000000 4  E 9C 00 00000000 4
E A4 1C 000000A8 5  E B0 1D 000000B4 5  E B8 1E 0000015C 5  E BC 1F 000000C0 5
E C4 05 00000002 5  E C8 05 00000001 5  E CC 00 00000000 5  E C8 05 00000000 5
E CC 00 00000000 5  E D0 06 000000C0 5  E D4 00 00000000 5  E D8 07 ABCDE000 5

// File: tb.f
rv_pkg.sv
reg_file.sv
id_stage.sv
ex_stage.sv
wb_stage.sv
ex_pipe_top.sv
ex_pipe_assert.sv
tb_ex_pipe.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ex_pipe -f tb.f -o sim_ex_pipe

out=$(./obj_dir/sim_ex_pipe || true)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
